/* Bender.yml */
package:
  name: busint

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - xbus_pkg.sv
      - xbus_ram.sv
      - xbus_io.sv
      - xbus_dma.sv
      - busint.sv
      - target: test
        files:
          - tb_busint.sv

/* busint.f */
+incdir+.
xbus_pkg.sv
xbus_ram.sv
xbus_io.sv
xbus_dma.sv
busint.sv
tb_busint.sv

/* busint.sv */
// Bus interface top; one master access or DMA word at a time, unanswered accesses end after 64 cycles
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module busint (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req,
   input  logic                    write,
   input  logic [`XBUS_ADDR_W-1:0] addr,
   input  logic [`XBUS_DATA_W-1:0] datain,
   output logic [`XBUS_DATA_W-1:0] dataout,
   output logic                    ack,
   output logic                    load,
   output logic                    interrupt,
   input  logic [15:0]             kb_data,
   input  logic                    kb_ready,
   input  logic [11:0]             ms_x,
   input  logic [11:0]             ms_y,
   input  logic [2:0]              ms_button,
   input  logic                    ms_ready,
   input  logic [`XBUS_DATA_W-1:0] blk_data,
   input  logic                    blk_valid,
   output logic                    blk_rdy
);

   import xbus_pkg::*;

   xbus_state_t             state;
   xbus_state_t             state_ns;
   logic [5:0]              timeout_count;
   logic                    timedout;
   logic                    req_valid;
   logic                    device_ack;
   logic                    busgrant;
   xbus_req_t               master_bus;
   xbus_req_t               ram_bus;
   logic                    ram_req;
   xbus_rsp_t               ram_rsp;
   xbus_rsp_t               io_rsp;
   xbus_rsp_t               dma_rsp;
   xbus_req_t               dma_mbus;
   xbus_rsp_t               dma_mrsp;
   logic                    dma_mreq;
   logic                    dma_busreq;
   logic                    io_interrupt;
   logic                    dma_interrupt;
   logic [`XBUS_DATA_W-1:0] read_data;

   assign master_bus = '{addr: addr, data: datain, write: write};

   // Devices only see the master request while in REQ
   assign req_valid = req & (state == REQ);
   assign busgrant  = state == SLAVE;

   //////////////////////////////////////////////////////////////////////
   // Devices

   // RAM port belongs to the DMA while it holds the bus
   assign ram_req  = busgrant ? dma_mreq : req_valid;
   assign ram_bus  = busgrant ? dma_mbus : master_bus;
   assign dma_mrsp = busgrant ? ram_rsp : '0;

   xbus_ram ram (
      .clk   (clk),
      .reset (reset),
      .req   (ram_req),
      .bus   (ram_bus),
      .rsp   (ram_rsp)
   );

   xbus_io io (
      .clk       (clk),
      .reset     (reset),
      .req       (req_valid),
      .bus       (master_bus),
      .rsp       (io_rsp),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .interrupt (io_interrupt)
   );

   xbus_dma dma (
      .clk       (clk),
      .reset     (reset),
      .req       (req_valid),
      .bus       (master_bus),
      .rsp       (dma_rsp),
      .blk_data  (blk_data),
      .blk_valid (blk_valid),
      .blk_rdy   (blk_rdy),
      .busreq    (dma_busreq),
      .busgrant  (busgrant),
      .mreq      (dma_mreq),
      .mbus      (dma_mbus),
      .mrsp      (dma_mrsp),
      .interrupt (dma_interrupt)
   );

   //////////////////////////////////////////////////////////////////////
   // Bus state machine, master before DMA

   assign device_ack = ram_rsp.ack | io_rsp.ack | dma_rsp.ack | timedout;

   always_comb begin
      state_ns = state;
      case (state)
         IDLE: begin
            if (req) begin
               state_ns = REQ;
            end else if (dma_busreq) begin
               state_ns = SLAVE;
            end
         end
         REQ: begin
            if (device_ack) begin
               state_ns = WAIT;
            end
         end
         WAIT: begin
            if (!req) begin
               state_ns = IDLE;
            end
         end
         SLAVE: begin
            if (ram_rsp.ack) begin
               state_ns = SWAIT;
            end
         end
         SWAIT: begin
            if (!dma_busreq) begin
               state_ns = IDLE;
            end
         end
         default: state_ns = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_ns;
      end
   end

   // Bus timeout, counts REQ cycles only
   always_ff @(posedge clk) begin
      if (reset) begin
         timeout_count <= '0;
      end else if (state == REQ) begin
         if (!timedout) begin
            timeout_count <= timeout_count + 6'd1;
         end
      end else begin
         timeout_count <= '0;
      end
   end

   assign timedout = timeout_count == 6'(`XBUS_TIMEOUT);

   //////////////////////////////////////////////////////////////////////
   // Read data and master handshake

   // Nothing decoded means a timeout, which reads as zero
   always_comb begin
      if (ram_rsp.decode) begin
         read_data = ram_rsp.data;
      end else if (io_rsp.decode) begin
         read_data = io_rsp.data;
      end else if (dma_rsp.decode) begin
         read_data = dma_rsp.data;
      end else begin
         read_data = '0;
      end
   end

   assign load = device_ack & ~write & (state == REQ);
   assign ack  = load | (state == WAIT);

   always_ff @(posedge clk) begin
      if (load) begin
         dataout <= read_data;
      end
   end

   assign interrupt = io_interrupt | dma_interrupt;

   a_state_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(state));

   a_one_decode: assert property (@(posedge clk) disable iff (reset)
      (state == REQ) |-> $onehot0({ram_rsp.decode, io_rsp.decode, dma_rsp.decode}));

   a_ack_in_bus_cycle: assert property (@(posedge clk) disable iff (reset)
      (ack | ram_rsp.ack | io_rsp.ack | dma_rsp.ack) |-> state inside {REQ, WAIT, SLAVE});

endmodule

`default_nettype wire

/* busint_patterns.txt */
# Columns are test name, operation, address, data and expected value, all hex
# Block lines give the word count as address and the first word as data, a zero count waits
ram_wr_lo     write 000010 11111111 0
ram_wr_mid    write 000011 a5a5a5a5 0
ram_wr_top    write 000fff 33333333 0
ram_rd_lo     read  000010 0 11111111
ram_rd_mid    read  000011 0 a5a5a5a5
ram_rd_top    read  000fff 0 33333333
unmapped_lo   read  001000 0 0
unmapped_hi   read  200000 0 0
key_press     key   0 00001234 0
key_masked    irq   0 0 0
key_status    read  3ff502 0 1
key_enable    write 3ff503 1 0
key_irq       irq   0 0 1
key_read      read  3ff500 0 1234
key_cleared   irq   0 0 0
mouse_move    mouse 0 05abc123 0
mouse_masked  irq   0 0 0
mouse_status  read  3ff502 0 2
mouse_enable  write 3ff503 3 0
mouse_irq     irq   0 0 1
mouse_read    read  3ff501 0 05abc123
mouse_cleared irq   0 0 0
dma_target    write 3ff580 100 0
dma_count     write 3ff581 3 0
dma_start     write 3ff582 3 0
dma_stream    block 3 c0de0000 0
dma_drain     block 0 0 0
dma_done      read  3ff583 0 2
dma_irq       irq   0 0 1
dma_word0     read  000100 0 c0de0000
dma_word1     read  000101 0 c0de0001
dma_word2     read  000102 0 c0de0002
dma_ack_done  write 3ff583 0 0
dma_irq_off   irq   0 0 0
mix_target    write 3ff580 200 0
mix_count     write 3ff581 5 0
mix_start     write 3ff582 1 0
mix_stream    block 5 d0000000 0
mix_rd_lo     read  000010 0 11111111
mix_rd_top    read  000fff 0 33333333
mix_rd_mid    read  000011 0 a5a5a5a5
mix_rd_again  read  000010 0 11111111
mix_drain     block 0 0 0
mix_done      read  3ff583 0 2
mix_word0     read  000200 0 d0000000
mix_word1     read  000201 0 d0000001
mix_word2     read  000202 0 d0000002
mix_word3     read  000203 0 d0000003
mix_word4     read  000204 0 d0000004

/* tb_busint.sv */
// Runs busint_patterns.txt from the project root, at most 64 lines; one block stream runs at a time
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module tb_busint;

   localparam int MAX_LINES = 64;
   // One cycle to reach REQ, then the full timeout window
   localparam int ACK_LIMIT = `XBUS_TIMEOUT + 2;

   logic                    clk;
   logic                    reset;
   logic                    req;
   logic                    write;
   logic [`XBUS_ADDR_W-1:0] addr;
   logic [`XBUS_DATA_W-1:0] datain;
   logic [`XBUS_DATA_W-1:0] dataout;
   logic                    ack;
   logic                    load;
   logic                    interrupt;
   logic [15:0]             kb_data;
   logic                    kb_ready;
   logic [11:0]             ms_x;
   logic [11:0]             ms_y;
   logic [2:0]              ms_button;
   logic                    ms_ready;
   logic [`XBUS_DATA_W-1:0] blk_data;
   logic                    blk_valid;
   logic                    blk_rdy;

   // Pattern table
   logic [8*20-1:0] names   [MAX_LINES];
   logic [8*8-1:0]  ops     [MAX_LINES];
   logic [31:0]     addrs   [MAX_LINES];
   logic [31:0]     datas   [MAX_LINES];
   logic [31:0]     expects [MAX_LINES];
   int              line_count;
   int              block_words;
   int              watch_cycles;

   // Block stream state, shared with the main sequence
   logic            stream_busy;
   int              stream_left;
   logic [31:0]     stream_word;
   logic [8*20-1:0] stream_name;

   busint busint_inst (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .write     (write),
      .addr      (addr),
      .datain    (datain),
      .dataout   (dataout),
      .ack       (ack),
      .load      (load),
      .interrupt (interrupt),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .blk_data  (blk_data),
      .blk_valid (blk_valid),
      .blk_rdy   (blk_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Operations

   task automatic abort_run(input string why);
      $display("%0s", why);
      $display("Result: FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   // Full master handshake for one read or write line
   task automatic run_access(input int idx);
      int   waited;
      int   loads;
      logic is_read;
      is_read = ops[idx] == "read";
      @(posedge clk);
      req    <= 1'b1;
      write  <= ~is_read;
      addr   <= addrs[idx][`XBUS_ADDR_W-1:0];
      datain <= datas[idx];
      @(negedge clk);
      waited = 1;
      loads  = int'(load);
      while (!ack && waited < ACK_LIMIT) begin
         @(negedge clk);
         waited++;
         loads += int'(load);
      end
      assert (ack) else
         abort_run($sformatf("Test %0s got no ack within %0d cycles", names[idx], ACK_LIMIT));
      // dataout is valid from the cycle after load
      @(negedge clk);
      loads += int'(load);
      if (is_read) begin
         assert (dataout == expects[idx]) else
            abort_run($sformatf("Error: test %0s expected %h actual %h",
                                names[idx], expects[idx], dataout));
      end
      @(posedge clk);
      req <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      assert (!ack) else
         abort_run($sformatf("Test %0s kept ack high after req dropped", names[idx]));
      assert (loads == int'(is_read)) else
         abort_run($sformatf("Error: test %0s load pulses expected %0d actual %0d",
                             names[idx], int'(is_read), loads));
   endtask

   task automatic pulse_key(input logic [15:0] word);
      @(posedge clk);
      kb_data  <= word;
      kb_ready <= 1'b1;
      @(posedge clk);
      kb_ready <= 1'b0;
   endtask

   // Report word is buttons, y, x from the top
   task automatic pulse_mouse(input logic [26:0] word);
      @(posedge clk);
      ms_button <= word[26:24];
      ms_y      <= word[23:12];
      ms_x      <= word[11:0];
      ms_ready  <= 1'b1;
      @(posedge clk);
      ms_ready <= 1'b0;
   endtask

   task automatic check_irq(input int idx);
      @(negedge clk);
      assert (interrupt == expects[idx][0]) else
         abort_run($sformatf("Error: test %0s expected %h actual %h",
                             names[idx], expects[idx][0], interrupt));
   endtask

   // Nonzero count starts a background stream, zero count waits for it
   task automatic queue_block(input int idx);
      wait (!stream_busy);
      if (addrs[idx] != 0) begin
         stream_name = names[idx];
         stream_word = datas[idx];
         stream_left = addrs[idx];
         stream_busy = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Block device

   initial begin
      forever begin
         wait (stream_busy === 1'b1);
         while (stream_left > 0) begin
            repeat ($urandom_range(4)) @(posedge clk);
            @(negedge clk);
            while (!blk_rdy) @(negedge clk);
            @(posedge clk);
            blk_data  <= stream_word;
            blk_valid <= 1'b1;
            @(posedge clk);
            blk_valid <= 1'b0;
            // Accepted word fills the one-word buffer
            @(negedge clk);
            assert (!blk_rdy) else
               abort_run($sformatf("Error: test %0s blk_rdy expected %0d actual %0d",
                                   stream_name, 0, blk_rdy));
            stream_word = stream_word + 1;
            stream_left--;
         end
         // Buffer empties once the last word is in RAM
         @(negedge clk);
         while (!blk_rdy) @(negedge clk);
         stream_busy = 1'b0;
      end
   end

   initial begin
      wait (watch_cycles > 0);
      repeat (watch_cycles) @(posedge clk);
      abort_run($sformatf("Timeout after %0d cycles without finishing", watch_cycles));
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int              fd;
      int              n;
      int              i;
      int              seed;
      int              rnd;
      logic [8*128-1:0] text;
      logic [8*20-1:0] f_name;
      logic [8*8-1:0]  f_op;
      logic [31:0]     f_addr;
      logic [31:0]     f_data;
      logic [31:0]     f_exp;
      reset       = 1'b1;
      req         = 1'b0;
      write       = 1'b0;
      addr        = '0;
      datain      = '0;
      kb_data     = '0;
      kb_ready    = 1'b0;
      ms_x        = '0;
      ms_y        = '0;
      ms_button   = '0;
      ms_ready    = 1'b0;
      blk_data    = '0;
      blk_valid   = 1'b0;
      stream_busy = 1'b0;
      stream_left = 0;
      stream_name = '0;
      seed        = 45247;
      rnd         = $urandom(seed);

      fd = $fopen("busint_patterns.txt", "r");
      assert (fd != 0) else abort_run("Cannot open busint_patterns.txt");
      text = '0;
      while ($fgets(text, fd) != 0) begin
         n = $sscanf(text, "%s %s %h %h %h", f_name, f_op, f_addr, f_data, f_exp);
         if (n == 5) begin
            assert (line_count < MAX_LINES) else abort_run("Too many pattern lines");
            names[line_count]   = f_name;
            ops[line_count]     = f_op;
            addrs[line_count]   = f_addr;
            datas[line_count]   = f_data;
            expects[line_count] = f_exp;
            if (f_op == "block") begin
               block_words += f_addr;
            end
            line_count++;
         end
         text = '0;
      end
      $fclose(fd);
      watch_cycles = 200 * (line_count + 1) + 100 * block_words;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      for (i = 0; i < line_count; i++) begin
         repeat ($urandom_range(3)) @(posedge clk);
         case (ops[i])
            "read", "write": run_access(i);
            "key":           pulse_key(datas[i][15:0]);
            "mouse":         pulse_mouse(datas[i][26:0]);
            "block":         queue_block(i);
            "irq":           check_irq(i);
            default: abort_run($sformatf("Test %0s has an unknown operation", names[i]));
         endcase
      end
      wait (!stream_busy);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* xbus_dma.sv */
// Block DMA into RAM, one buffered word; words arriving while idle or with the buffer full are dropped
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module xbus_dma (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req,
   input  xbus_pkg::xbus_req_t     bus,
   output xbus_pkg::xbus_rsp_t     rsp,
   input  logic [`XBUS_DATA_W-1:0] blk_data,
   input  logic                    blk_valid,
   output logic                    blk_rdy,
   output logic                    busreq,
   input  logic                    busgrant,
   output logic                    mreq,
   output xbus_pkg::xbus_req_t     mbus,
   input  xbus_pkg::xbus_rsp_t     mrsp,
   output logic                    interrupt
);

   localparam logic [`XBUS_ADDR_W-1:0] BASE = `XBUS_DMA_BASE;

   logic                    decode;
   logic                    access;
   logic                    ack_q;
   logic [1:0]              offset;
   logic [`XBUS_ADDR_W-1:0] target;
   logic [`XBUS_ADDR_W-1:0] count;
   logic                    busy;
   logic                    done;
   logic                    irq_en;
   logic                    full;
   logic [`XBUS_DATA_W-1:0] word;
   logic [`XBUS_DATA_W-1:0] rdata;
   logic [`XBUS_DATA_W-1:0] rdata_q;
   logic                    take;
   logic                    wdone;

   assign decode = bus.addr[`XBUS_ADDR_W-1:2] == BASE[`XBUS_ADDR_W-1:2];
   assign offset = bus.addr[1:0];
   assign access = req & decode & ~ack_q;

   // Block word into the buffer, buffer word into RAM
   assign take  = busy & blk_valid & ~full;
   assign wdone = mreq & mrsp.ack;

   always_comb begin
      case (offset)
         2'd0:    rdata = `XBUS_DATA_W'(target);
         2'd1:    rdata = `XBUS_DATA_W'(count);
         2'd2:    rdata = `XBUS_DATA_W'({irq_en, busy});
         default: rdata = `XBUS_DATA_W'({done, busy});
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Registers and transfer control

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q  <= 1'b0;
         target <= '0;
         count  <= '0;
         busy   <= 1'b0;
         done   <= 1'b0;
         irq_en <= 1'b0;
         full   <= 1'b0;
         mreq   <= 1'b0;
      end else begin
         ack_q <= access;
         // Held through the RAM ack cycle, never past the grant
         mreq  <= busgrant & full & ~mrsp.ack;
         if (take) begin
            full <= 1'b1;
         end else if (wdone) begin
            full <= 1'b0;
         end
         if (wdone) begin
            target <= target + 1'b1;
            count  <= count - 1'b1;
            if (count == `XBUS_ADDR_W'(1)) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end else if (access && bus.write) begin
            case (offset)
               2'd0: target <= bus.data[`XBUS_ADDR_W-1:0];
               2'd1: count <= bus.data[`XBUS_ADDR_W-1:0];
               2'd2: begin
                  irq_en <= bus.data[1];
                  // Start with nothing to move finishes at once
                  if (bus.data[0]) begin
                     if (count != '0) begin
                        busy <= 1'b1;
                     end else begin
                        done <= 1'b1;
                     end
                  end
               end
               default: done <= 1'b0;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         word <= blk_data;
      end
      if (access) begin
         rdata_q <= rdata;
      end
   end

   assign blk_rdy = ~full;
   assign busreq  = full;

   assign mbus.addr  = target;
   assign mbus.data  = word;
   assign mbus.write = 1'b1;

   assign rsp.data   = rdata_q;
   assign rsp.ack    = ack_q;
   assign rsp.decode = decode;

   assign interrupt = done & irq_en;

   a_mreq_granted: assert property (@(posedge clk) disable iff (reset)
      mreq |-> busgrant);

endmodule

`default_nettype wire

/* xbus_io.sv */
// Keyboard and mouse latches; a new ready pulse overwrites unread data, a set wins over a read clear
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module xbus_io (
   input  logic                clk,
   input  logic                reset,
   input  logic                req,
   input  xbus_pkg::xbus_req_t bus,
   output xbus_pkg::xbus_rsp_t rsp,
   input  logic [15:0]         kb_data,
   input  logic                kb_ready,
   input  logic [11:0]         ms_x,
   input  logic [11:0]         ms_y,
   input  logic [2:0]          ms_button,
   input  logic                ms_ready,
   output logic                interrupt
);

   localparam logic [`XBUS_ADDR_W-1:0] BASE = `XBUS_IO_BASE;

   logic                    decode;
   logic                    access;
   logic                    ack_q;
   logic [1:0]              offset;
   logic                    rd_kb;
   logic                    rd_ms;
   logic [15:0]             kb_word;
   logic [26:0]             ms_word;
   // Bit 0 keyboard, bit 1 mouse
   logic [1:0]              pending;
   logic [1:0]              enable;
   logic [`XBUS_DATA_W-1:0] rdata;
   logic [`XBUS_DATA_W-1:0] rdata_q;

   assign decode = bus.addr[`XBUS_ADDR_W-1:2] == BASE[`XBUS_ADDR_W-1:2];
   assign offset = bus.addr[1:0];

   // One access per held request, acked the next cycle
   assign access = req & decode & ~ack_q;
   assign rd_kb  = access & ~bus.write & (offset == 2'd0);
   assign rd_ms  = access & ~bus.write & (offset == 2'd1);

   always_comb begin
      case (offset)
         2'd0:    rdata = `XBUS_DATA_W'(kb_word);
         2'd1:    rdata = `XBUS_DATA_W'(ms_word);
         2'd2:    rdata = `XBUS_DATA_W'(pending);
         default: rdata = `XBUS_DATA_W'(enable);
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q   <= 1'b0;
         pending <= 2'b00;
         enable  <= 2'b00;
      end else begin
         ack_q      <= access;
         pending[0] <= kb_ready | (pending[0] & ~rd_kb);
         pending[1] <= ms_ready | (pending[1] & ~rd_ms);
         // Only the enable register takes writes
         if (access && bus.write && offset == 2'd3) begin
            enable <= bus.data[1:0];
         end
      end
   end

   // Device data and read return
   always_ff @(posedge clk) begin
      if (kb_ready) begin
         kb_word <= kb_data;
      end
      if (ms_ready) begin
         ms_word <= {ms_button, ms_y, ms_x};
      end
      if (access) begin
         rdata_q <= rdata;
      end
   end

   assign rsp.data   = rdata_q;
   assign rsp.ack    = ack_q;
   assign rsp.decode = decode;

   assign interrupt = |(pending & enable);

endmodule

`default_nettype wire

/* xbus_params.svh */
// Sizing and address map; I/O and DMA windows are four words each and must stay clear of the RAM
`ifndef XBUS_PARAMS_SVH
`define XBUS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths

`define XBUS_ADDR_W 22
`define XBUS_DATA_W 32

//////////////////////////////////////////////////////////////////////
// Address map

// RAM decodes from word address zero upward
`define XBUS_RAM_WORDS 4096

// Register windows, four words each
`define XBUS_IO_BASE 22'h3ff500
`define XBUS_DMA_BASE 22'h3ff580

// Cycles in REQ before an unanswered access completes with zero data
`define XBUS_TIMEOUT 63

`endif

/* xbus_pkg.sv */
// Bus types shared by the interface and its devices; field widths come from xbus_params.svh
`default_nettype none

`include "xbus_params.svh"

package xbus_pkg;

   // What a master presents to a device
   typedef struct packed {
      logic [`XBUS_ADDR_W-1:0] addr;
      logic [`XBUS_DATA_W-1:0] data;
      logic                    write;
   } xbus_req_t;

   // What each device returns
   // ack is a single-cycle pulse, data valid in that cycle
   typedef struct packed {
      logic [`XBUS_DATA_W-1:0] data;
      logic                    ack;
      logic                    decode;
   } xbus_rsp_t;

   // Bus owner state, IDLE is the all-zero code
   typedef enum logic [3:0] {
      IDLE  = 4'b0000,
      REQ   = 4'b0001,
      WAIT  = 4'b0010,
      SLAVE = 4'b0100,
      SWAIT = 4'b1000
   } xbus_state_t;

endpackage

`default_nettype wire

/* xbus_ram.sv */
// On-chip word RAM at address zero; one access in flight, ack two cycles after acceptance
`timescale 1ns/1ps
`default_nettype none

`include "xbus_params.svh"

module xbus_ram (
   input  logic                clk,
   input  logic                reset,
   input  logic                req,
   input  xbus_pkg::xbus_req_t bus,
   output xbus_pkg::xbus_rsp_t rsp
);

   localparam int AW = $clog2(`XBUS_RAM_WORDS);

   logic [`XBUS_DATA_W-1:0] mem [`XBUS_RAM_WORDS];

   logic                    decode;
   logic                    accept;
   logic                    s1_valid;
   logic                    s2_valid;
   logic [AW-1:0]           s1_addr;
   logic [`XBUS_DATA_W-1:0] s1_data;
   logic                    s1_write;
   logic [`XBUS_DATA_W-1:0] rdata;

   assign decode = bus.addr < `XBUS_RAM_WORDS;

   // The gated request stays high until ack, so only take it when idle
   assign accept = req & decode & ~s1_valid & ~s2_valid;

   //////////////////////////////////////////////////////////////////////
   // Pipeline control

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= accept;
         s2_valid <= s1_valid;
      end
   end

   // Capture the access in stage one
   always_ff @(posedge clk) begin
      if (accept) begin
         s1_addr  <= bus.addr[AW-1:0];
         s1_data  <= bus.data;
         s1_write <= bus.write;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Array, accessed in stage one

   always_ff @(posedge clk) begin
      if (s1_valid) begin
         if (s1_write) begin
            mem[s1_addr] <= s1_data;
         end
         rdata <= mem[s1_addr];
      end
   end

   assign rsp.data   = rdata;
   assign rsp.ack    = s2_valid;
   assign rsp.decode = decode;

   // A new access only starts after the previous one has been acked
   a_single_access: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |-> !(s1_valid || s2_valid));

endmodule

`default_nettype wire
